/* src/mips_isa_pkg.sv */
package mips_isa_pkg;

	// primary opcode, instruction bits 31..26
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b,
		// not a real MIPS opcode, ends the program
		OP_HALT  = 6'h3f
	} opcode_e;

	// funct field of r-type, bits 5..0
	typedef enum logic [5:0] {
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_XOR  = 6'h26,
		F_SLT  = 6'h2a
	} funct_e;

	// field layout
	localparam int op_lsb = 26;
	localparam int op_bits = 6;
	localparam int rs_lsb = 21;
	localparam int rt_lsb = 16;
	localparam int rd_lsb = 11;
	localparam int reg_bits = 5;
	localparam int funct_bits = 6;
	localparam int imm_bits = 16;
	localparam int target_bits = 26;

	// halt word, all other fields zero
	localparam logic [31:0] halt_instr = {OP_HALT, 26'd0};

endpackage

/* src/mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

	// datapath and instruction width
	localparam int len_data = 32;

	// alu operations, ALU_ADD doubles as the bubble value
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI
	} alu_op_e;

	// execute stage controls
	typedef struct packed {
		alu_op_e alu_op;
		// operand b from immediate
		logic    imm_sel;
		// immediate without sign extension (andi, ori)
		logic    zero_ext;
	} ex_ctrl_t;

	// memory stage controls
	typedef struct packed {
		logic mem_read;
		logic mem_write;
		logic branch_eq;
		logic branch_ne;
		logic halt;
	} mem_ctrl_t;

	// write-back controls
	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

endpackage

/* src/pipe_regs_if.sv */
`timescale 1ns/10ps

////////////////////////////////////////////////////////////////////
// IF -> ID
////////////////////////////////////////////////////////////////////
interface if_id_bus;
	logic [mips_ctrl_pkg::len_data-1:0] pc_plus4;
	logic [mips_ctrl_pkg::len_data-1:0] instruction;
	// back from decode
	logic                               stall;
	logic                               jump;
	logic [mips_ctrl_pkg::len_data-1:0] jump_target;

	modport src (output pc_plus4, instruction, input stall, jump, jump_target);
	modport dst (input pc_plus4, instruction, output stall, jump, jump_target);
endinterface

////////////////////////////////////////////////////////////////////
// ID -> EX
////////////////////////////////////////////////////////////////////
interface id_ex_bus;
	logic [mips_ctrl_pkg::len_data-1:0] pc_plus4;
	logic [mips_ctrl_pkg::len_data-1:0] reg1;
	logic [mips_ctrl_pkg::len_data-1:0] reg2;
	logic [mips_ctrl_pkg::len_data-1:0] imm;
	logic [mips_isa_pkg::reg_bits-1:0]  rs;
	logic [mips_isa_pkg::reg_bits-1:0]  rt;
	logic [mips_isa_pkg::reg_bits-1:0]  dest;
	mips_ctrl_pkg::ex_ctrl_t            ex;
	mips_ctrl_pkg::mem_ctrl_t           mem;
	mips_ctrl_pkg::wb_ctrl_t            wb;
	// taken branch, kills the decode slot
	logic                               flush;

	modport src (output pc_plus4, reg1, reg2, imm, rs, rt, dest, ex, mem, wb, input flush);
	modport dst (input pc_plus4, reg1, reg2, imm, rs, rt, dest, ex, mem, wb, output flush);
endinterface

////////////////////////////////////////////////////////////////////
// EX -> MEM, plus branch and write-back returns
////////////////////////////////////////////////////////////////////
interface ex_mem_bus;
	logic [mips_ctrl_pkg::len_data-1:0] alu_out;
	logic [mips_ctrl_pkg::len_data-1:0] store_data;
	logic                               zero;
	logic [mips_ctrl_pkg::len_data-1:0] branch_target;
	logic [mips_isa_pkg::reg_bits-1:0]  dest;
	mips_ctrl_pkg::mem_ctrl_t           mem;
	mips_ctrl_pkg::wb_ctrl_t            wb;
	// driven by the memory stage
	logic                               branch_taken;
	logic                               wb_reg_write;
	logic [mips_isa_pkg::reg_bits-1:0]  wb_reg;
	logic [mips_ctrl_pkg::len_data-1:0] wb_data;

	modport src (output alu_out, store_data, zero, branch_target, dest, mem, wb,
		input branch_taken, wb_reg_write, wb_reg, wb_data);
	modport dst (input alu_out, store_data, zero, branch_target, dest, mem, wb,
		output branch_taken, wb_reg_write, wb_reg, wb_data);
	modport fetch (input branch_taken, branch_target);
	modport writeback (input wb_reg_write, wb_reg, wb_data);
endinterface

/* src/stage_if.sv */
`timescale 1ns/10ps

module stage_if #(
	parameter int len_addr = 7
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               freeze,
	input  logic [len_addr-1:0]                in_addr_mem_inst,
	input  logic [mips_ctrl_pkg::len_data-1:0] in_ins_to_mem,
	input  logic                               wea_ram_inst,
	input  logic                               halt,
	if_id_bus.src                              ifid,
	ex_mem_bus.fetch                           ex_back,
	output logic [mips_ctrl_pkg::len_data-1:0] out_pc
);

	logic [mips_ctrl_pkg::len_data-1:0] pc;
	logic [mips_ctrl_pkg::len_data-1:0] pc_next;
	logic [mips_ctrl_pkg::len_data-1:0] pc_plus4;
	logic [mips_ctrl_pkg::len_data-1:0] fetched;
	logic [mips_ctrl_pkg::len_data-1:0] imem [2**len_addr];

	assign pc_plus4 = pc + 32'd4;
	// word index into instruction memory
	assign fetched = imem[pc[len_addr+1:2]];
	assign out_pc = pc;

	// next pc, highest priority first
	always_comb begin
		if (halt || freeze)
			pc_next = pc;
		else if (ex_back.branch_taken)
			pc_next = ex_back.branch_target;
		else if (ifid.jump)
			pc_next = ifid.jump_target;
		else if (ifid.stall)
			pc_next = pc;
		else
			pc_next = pc_plus4;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else
			pc <= pc_next;
	end

	// debug load port, ignores freeze
	always_ff @(posedge clk) begin
		if (wea_ram_inst)
			imem[in_addr_mem_inst] <= in_ins_to_mem;
	end

	// IF/ID register, all-zero word is the bubble
	always_ff @(posedge clk) begin
		if (rst) begin
			ifid.instruction <= '0;
			ifid.pc_plus4 <= '0;
		end else if (!freeze) begin
			if (ex_back.branch_taken || ifid.jump) begin
				ifid.instruction <= '0;
			end else if (!ifid.stall) begin
				ifid.instruction <= fetched;
				ifid.pc_plus4 <= pc_plus4;
			end
		end
	end

endmodule

/* src/stage_id.sv */
`timescale 1ns/10ps

module stage_id (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               freeze,
	if_id_bus.dst                              ifid,
	id_ex_bus.src                              idex,
	ex_mem_bus.writeback                       wb,
	input  logic [mips_isa_pkg::reg_bits-1:0]  debug_reg_addr,
	output logic [mips_ctrl_pkg::len_data-1:0] debug_reg_data
);

	localparam int rb = mips_isa_pkg::reg_bits;
	localparam int ib = mips_isa_pkg::imm_bits;

	logic [mips_ctrl_pkg::len_data-1:0] instr;
	mips_isa_pkg::opcode_e              opcode;
	mips_isa_pkg::funct_e               funct;
	logic [rb-1:0]                      rs;
	logic [rb-1:0]                      rt;
	logic [rb-1:0]                      rd;
	logic [rb-1:0]                      dest_d;
	logic [mips_ctrl_pkg::len_data-1:0] imm_ext;
	logic [mips_ctrl_pkg::len_data-1:0] rd1;
	logic [mips_ctrl_pkg::len_data-1:0] rd2;
	logic [mips_ctrl_pkg::len_data-1:0] rf [32];
	mips_ctrl_pkg::ex_ctrl_t            ex_d;
	mips_ctrl_pkg::mem_ctrl_t           mem_d;
	mips_ctrl_pkg::wb_ctrl_t            wb_d;
	logic                               load_use;

	////////////////////////////////////////////////////////////////////
	// fields
	////////////////////////////////////////////////////////////////////
	assign instr = ifid.instruction;
	assign opcode = mips_isa_pkg::opcode_e'(instr[mips_isa_pkg::op_lsb +: mips_isa_pkg::op_bits]);
	assign funct = mips_isa_pkg::funct_e'(instr[mips_isa_pkg::funct_bits-1:0]);
	assign rs = instr[mips_isa_pkg::rs_lsb +: rb];
	assign rt = instr[mips_isa_pkg::rt_lsb +: rb];
	assign rd = instr[mips_isa_pkg::rd_lsb +: rb];
	assign imm_ext = {{(mips_ctrl_pkg::len_data - ib){instr[ib-1]}}, instr[ib-1:0]};

	// decoder, defaults give a bubble
	always_comb begin
		ex_d = '0;
		mem_d = '0;
		wb_d = '0;
		dest_d = rt;
		case (opcode)
			mips_isa_pkg::OP_RTYPE: begin
				dest_d = rd;
				wb_d.reg_write = 1'b1;
				case (funct)
					mips_isa_pkg::F_ADDU: ex_d.alu_op = mips_ctrl_pkg::ALU_ADD;
					mips_isa_pkg::F_SUBU: ex_d.alu_op = mips_ctrl_pkg::ALU_SUB;
					mips_isa_pkg::F_AND:  ex_d.alu_op = mips_ctrl_pkg::ALU_AND;
					mips_isa_pkg::F_OR:   ex_d.alu_op = mips_ctrl_pkg::ALU_OR;
					mips_isa_pkg::F_XOR:  ex_d.alu_op = mips_ctrl_pkg::ALU_XOR;
					mips_isa_pkg::F_SLT:  ex_d.alu_op = mips_ctrl_pkg::ALU_SLT;
					// unknown funct (incl. the all-zero nop) writes nothing
					default: wb_d.reg_write = 1'b0;
				endcase
			end
			mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_LUI: begin
				ex_d.alu_op = (opcode == mips_isa_pkg::OP_LUI) ? mips_ctrl_pkg::ALU_LUI
					: mips_ctrl_pkg::ALU_ADD;
				ex_d.imm_sel = 1'b1;
				wb_d.reg_write = 1'b1;
			end
			mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI: begin
				ex_d.alu_op = (opcode == mips_isa_pkg::OP_ANDI) ? mips_ctrl_pkg::ALU_AND
					: mips_ctrl_pkg::ALU_OR;
				ex_d.imm_sel = 1'b1;
				ex_d.zero_ext = 1'b1;
				wb_d.reg_write = 1'b1;
			end
			mips_isa_pkg::OP_LW: begin
				ex_d.imm_sel = 1'b1;
				mem_d.mem_read = 1'b1;
				wb_d.reg_write = 1'b1;
				wb_d.mem_to_reg = 1'b1;
			end
			mips_isa_pkg::OP_SW: begin
				ex_d.imm_sel = 1'b1;
				mem_d.mem_write = 1'b1;
			end
			mips_isa_pkg::OP_BEQ, mips_isa_pkg::OP_BNE: begin
				// compare by subtraction, zero flag decides in MEM
				ex_d.alu_op = mips_ctrl_pkg::ALU_SUB;
				mem_d.branch_eq = (opcode == mips_isa_pkg::OP_BEQ);
				mem_d.branch_ne = (opcode == mips_isa_pkg::OP_BNE);
			end
			mips_isa_pkg::OP_HALT: mem_d.halt = 1'b1;
			default: ;
		endcase
	end

	// jump resolves here, one slot lost
	assign ifid.jump = (opcode == mips_isa_pkg::OP_J);
	assign ifid.jump_target = {ifid.pc_plus4[31:28],
		instr[mips_isa_pkg::target_bits-1:0], 2'b00};

	// load in EX feeding either source field
	assign load_use = idex.mem.mem_read && (idex.dest != '0)
		&& ((idex.dest == rs) || (idex.dest == rt));
	assign ifid.stall = load_use;

	////////////////////////////////////////////////////////////////////
	// register file
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				rf[i] <= '0;
		end else if (!freeze && wb.wb_reg_write && (wb.wb_reg != '0)) begin
			rf[wb.wb_reg] <= wb.wb_data;
		end
	end

	// r0 reads zero, same-cycle write passes through
	assign rd1 = (rs == '0) ? '0 : (wb.wb_reg_write && (wb.wb_reg == rs)) ? wb.wb_data : rf[rs];
	assign rd2 = (rt == '0) ? '0 : (wb.wb_reg_write && (wb.wb_reg == rt)) ? wb.wb_data : rf[rt];
	assign debug_reg_data = rf[debug_reg_addr];

	// ID/EX register
	always_ff @(posedge clk) begin
		if (rst) begin
			idex.ex <= '0;
			idex.mem <= '0;
			idex.wb <= '0;
		end else if (!freeze) begin
			// bubble on taken branch or load-use
			idex.ex <= (idex.flush || load_use) ? '0 : ex_d;
			idex.mem <= (idex.flush || load_use) ? '0 : mem_d;
			idex.wb <= (idex.flush || load_use) ? '0 : wb_d;
		end
		if (!freeze) begin
			idex.pc_plus4 <= ifid.pc_plus4;
			idex.reg1 <= rd1;
			idex.reg2 <= rd2;
			idex.imm <= imm_ext;
			idex.rs <= rs;
			idex.rt <= rt;
			idex.dest <= dest_d;
		end
	end

endmodule

/* src/stage_ex.sv */
`timescale 1ns/10ps

module stage_ex (
	input  logic  clk,
	input  logic  rst,
	input  logic  freeze,
	id_ex_bus.dst idex,
	ex_mem_bus.src exmem
);

	logic [mips_ctrl_pkg::len_data-1:0] op_a;
	logic [mips_ctrl_pkg::len_data-1:0] fwd_b;
	logic [mips_ctrl_pkg::len_data-1:0] op_b;
	logic [mips_ctrl_pkg::len_data-1:0] imm_val;
	logic [mips_ctrl_pkg::len_data-1:0] alu_res;

	// decode slot dies with the taken branch
	assign idex.flush = exmem.branch_taken;

	////////////////////////////////////////////////////////////////////
	// forwarding, EX/MEM first then write-back port
	////////////////////////////////////////////////////////////////////
	always_comb begin
		if (exmem.wb.reg_write && (exmem.dest != '0) && (exmem.dest == idex.rs))
			op_a = exmem.alu_out;
		else if (exmem.wb_reg_write && (exmem.wb_reg != '0) && (exmem.wb_reg == idex.rs))
			op_a = exmem.wb_data;
		else
			op_a = idex.reg1;
	end

	always_comb begin
		if (exmem.wb.reg_write && (exmem.dest != '0) && (exmem.dest == idex.rt))
			fwd_b = exmem.alu_out;
		else if (exmem.wb_reg_write && (exmem.wb_reg != '0) && (exmem.wb_reg == idex.rt))
			fwd_b = exmem.wb_data;
		else
			fwd_b = idex.reg2;
	end

	// andi/ori take the raw 16 bits
	assign imm_val = idex.ex.zero_ext ? {16'd0, idex.imm[15:0]} : idex.imm;
	assign op_b = idex.ex.imm_sel ? imm_val : fwd_b;

	// alu
	always_comb begin
		case (idex.ex.alu_op)
			mips_ctrl_pkg::ALU_ADD: alu_res = op_a + op_b;
			mips_ctrl_pkg::ALU_SUB: alu_res = op_a - op_b;
			mips_ctrl_pkg::ALU_AND: alu_res = op_a & op_b;
			mips_ctrl_pkg::ALU_OR:  alu_res = op_a | op_b;
			mips_ctrl_pkg::ALU_XOR: alu_res = op_a ^ op_b;
			// signed compare
			mips_ctrl_pkg::ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
			mips_ctrl_pkg::ALU_LUI: alu_res = {imm_val[15:0], 16'd0};
			default: alu_res = '0;
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (rst) begin
			exmem.mem <= '0;
			exmem.wb <= '0;
		end else if (!freeze) begin
			exmem.mem <= exmem.branch_taken ? '0 : idex.mem;
			exmem.wb <= exmem.branch_taken ? '0 : idex.wb;
		end
		if (!freeze) begin
			exmem.alu_out <= alu_res;
			exmem.store_data <= fwd_b;
			exmem.zero <= (alu_res == '0);
			// word offset from the delay-free pc+4
			exmem.branch_target <= idex.pc_plus4 + {idex.imm[29:0], 2'b00};
			exmem.dest <= idex.dest;
		end
	end

endmodule

/* src/stage_mem.sv */
`timescale 1ns/10ps

module stage_mem #(
	parameter int len_dmem_addr = 7
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               freeze,
	ex_mem_bus.dst                             exmem,
	input  logic [len_dmem_addr-1:0]           debug_mem_addr,
	output logic [mips_ctrl_pkg::len_data-1:0] debug_mem_data,
	output logic                               halt_flag
);

	logic [mips_ctrl_pkg::len_data-1:0] dmem [2**len_dmem_addr];
	logic [len_dmem_addr-1:0]           word_addr;
	logic [mips_ctrl_pkg::len_data-1:0] load_q;
	logic [mips_ctrl_pkg::len_data-1:0] alu_q;
	logic [mips_isa_pkg::reg_bits-1:0]  dest_q;
	mips_ctrl_pkg::wb_ctrl_t            wb_q;

	// byte address to word index
	assign word_addr = exmem.alu_out[len_dmem_addr+1:2];
	assign debug_mem_data = dmem[debug_mem_addr];

	// branch decision, nothing redirects once halted
	assign exmem.branch_taken = !halt_flag
		&& ((exmem.mem.branch_eq && exmem.zero) || (exmem.mem.branch_ne && !exmem.zero));

	// stores behind a halt are dropped
	always_ff @(posedge clk) begin
		if (!freeze && !halt_flag && exmem.mem.mem_write)
			dmem[word_addr] <= exmem.store_data;
	end

	// MEM/WB register
	always_ff @(posedge clk) begin
		if (rst)
			wb_q <= '0;
		else if (!freeze)
			wb_q <= exmem.wb;
		if (!freeze) begin
			load_q <= dmem[word_addr];
			alu_q <= exmem.alu_out;
			dest_q <= exmem.dest;
		end
	end

	// sticky until reset
	always_ff @(posedge clk) begin
		if (rst)
			halt_flag <= 1'b0;
		else if (!freeze && exmem.mem.halt)
			halt_flag <= 1'b1;
	end

	// write-back port
	assign exmem.wb_reg_write = wb_q.reg_write && !halt_flag;
	assign exmem.wb_reg = dest_q;
	assign exmem.wb_data = wb_q.mem_to_reg ? load_q : alu_q;

endmodule

/* src/top_mips.sv */
`timescale 1ns/10ps

module top_mips #(
	parameter int len_addr = 7,
	parameter int len_dmem_addr = 7
) (
	input  logic                               clk,
	input  logic                               rst,
	// debug side
	input  logic                               debug_flag,
	input  logic [len_addr-1:0]                in_addr_mem_inst,
	input  logic [mips_ctrl_pkg::len_data-1:0] in_ins_to_mem,
	input  logic                               wea_ram_inst,
	input  logic [mips_isa_pkg::reg_bits-1:0]  debug_reg_addr,
	input  logic [len_dmem_addr-1:0]           debug_mem_addr,
	output logic [mips_ctrl_pkg::len_data-1:0] out_pc,
	output logic [mips_ctrl_pkg::len_data-1:0] debug_reg_data,
	output logic [mips_ctrl_pkg::len_data-1:0] debug_mem_data,
	output logic                               halt_flag
);

	////////////////////////////////////////////////////////////////////
	// stage-to-stage buses
	////////////////////////////////////////////////////////////////////
	if_id_bus  u_if_id_bus ();
	id_ex_bus  u_id_ex_bus ();
	ex_mem_bus u_ex_mem_bus ();

	////////////////////////////////////////////////////////////////////
	// stages, debug_flag freezes them all
	////////////////////////////////////////////////////////////////////
	stage_if #(
		.len_addr(len_addr)
	) u_stage_if (
		.clk(clk),
		.rst(rst),
		.freeze(debug_flag),
		.in_addr_mem_inst(in_addr_mem_inst),
		.in_ins_to_mem(in_ins_to_mem),
		.wea_ram_inst(wea_ram_inst),
		.halt(halt_flag),
		.ifid(u_if_id_bus.src),
		.ex_back(u_ex_mem_bus.fetch),
		.out_pc(out_pc)
	);

	stage_id u_stage_id (
		.clk(clk),
		.rst(rst),
		.freeze(debug_flag),
		.ifid(u_if_id_bus.dst),
		.idex(u_id_ex_bus.src),
		.wb(u_ex_mem_bus.writeback),
		.debug_reg_addr(debug_reg_addr),
		.debug_reg_data(debug_reg_data)
	);

	stage_ex u_stage_ex (
		.clk(clk),
		.rst(rst),
		.freeze(debug_flag),
		.idex(u_id_ex_bus.dst),
		.exmem(u_ex_mem_bus.src)
	);

	stage_mem #(
		.len_dmem_addr(len_dmem_addr)
	) u_stage_mem (
		.clk(clk),
		.rst(rst),
		.freeze(debug_flag),
		.exmem(u_ex_mem_bus.dst),
		.debug_mem_addr(debug_mem_addr),
		.debug_mem_data(debug_mem_data),
		.halt_flag(halt_flag)
	);

endmodule

/* verif/tb_top_mips.sv */
`timescale 1ns/10ps

module tb_top_mips;

	localparam int len_addr = 7;
	localparam int len_dmem_addr = 7;
	// 5 tests, each <= 40 instr x 4 cycles + reset, load, readout, hold, with margin
	localparam int timeout_cycles = 3000;

	logic                     clk = 1'b0;
	logic                     rst;
	logic                     debug_flag;
	logic [len_addr-1:0]      in_addr_mem_inst;
	logic [31:0]              in_ins_to_mem;
	logic                     wea_ram_inst;
	logic [4:0]               debug_reg_addr;
	logic [len_dmem_addr-1:0] debug_mem_addr;
	logic [31:0]              out_pc;
	logic [31:0]              debug_reg_data;
	logic [31:0]              debug_mem_data;
	logic                     halt_flag;

	// program under test and the expected end state
	logic [31:0] prog [$];
	logic [31:0] ref_regs [32];
	logic [31:0] ref_mem [2**len_dmem_addr];
	bit          mem_touched [2**len_dmem_addr];
	logic [31:0] lcg_state = 32'h046b2dce;
	int          checks = 0;
	int          errors = 0;
	int          tests = 0;
	int          cycle_count = 0;

	top_mips #(
		.len_addr(len_addr),
		.len_dmem_addr(len_dmem_addr)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.debug_flag(debug_flag),
		.in_addr_mem_inst(in_addr_mem_inst),
		.in_ins_to_mem(in_ins_to_mem),
		.wea_ram_inst(wea_ram_inst),
		.debug_reg_addr(debug_reg_addr),
		.debug_mem_addr(debug_mem_addr),
		.out_pc(out_pc),
		.debug_reg_data(debug_reg_data),
		.debug_mem_data(debug_mem_data),
		.halt_flag(halt_flag)
	);

	// 8 ns period
	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// program builder
	//////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// fields in bit order
	function automatic logic [31:0] rtype_word(mips_isa_pkg::funct_e f, int rs, int rt, int rd);
		return {mips_isa_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, f};
	endfunction

	function automatic logic [31:0] itype_word(mips_isa_pkg::opcode_e op, int rs, int rt, int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	// target given as a word index
	function automatic logic [31:0] jump_word(int index);
		return {mips_isa_pkg::OP_J, 26'(index)};
	endfunction

	task automatic emit(input logic [31:0] word);
		prog.push_back(word);
	endtask

	// lui/ori pair
	task automatic load_const(input int r, input logic [31:0] value);
		emit(itype_word(mips_isa_pkg::OP_LUI, 0, r, int'(value[31:16])));
		emit(itype_word(mips_isa_pkg::OP_ORI, r, r, int'(value[15:0])));
	endtask

	task automatic end_program();
		emit(mips_isa_pkg::halt_instr);
		// fetched behind the halt, must never retire
		repeat (4) emit(itype_word(mips_isa_pkg::OP_ADDIU, 1, 1, 1));
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model, one instruction at a time, no pipeline
	//////////////////////////////////////////////////////////////////////
	function automatic void run_isa();
		logic [31:0] pc;
		logic [31:0] next_pc;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] zimm;
		logic [31:0] addr;
		logic [4:0]  rd;
		logic [4:0]  rt;
		int          idx;
		int          steps;
		bit          done;
		for (int i = 0; i < 32; i++)
			ref_regs[i] = '0;
		for (int i = 0; i < 2**len_dmem_addr; i++)
			mem_touched[i] = 1'b0;
		pc = '0;
		steps = 0;
		done = 1'b0;
		while (!done) begin
			idx = int'(pc >> 2);
			if (idx >= prog.size() || steps >= 200) begin
				$display("reference model ran past the end of the program at pc %08h", pc);
				errors++;
				done = 1'b1;
			end else begin
				w = prog[idx];
				a = ref_regs[w[25:21]];
				b = ref_regs[w[20:16]];
				rt = w[20:16];
				rd = w[15:11];
				simm = {{16{w[15]}}, w[15:0]};
				zimm = {16'd0, w[15:0]};
				addr = a + simm;
				next_pc = pc + 32'd4;
				case (w[31:26])
					mips_isa_pkg::OP_RTYPE: begin
						case (w[5:0])
							mips_isa_pkg::F_ADDU: ref_regs[rd] = a + b;
							mips_isa_pkg::F_SUBU: ref_regs[rd] = a - b;
							mips_isa_pkg::F_AND:  ref_regs[rd] = a & b;
							mips_isa_pkg::F_OR:   ref_regs[rd] = a | b;
							mips_isa_pkg::F_XOR:  ref_regs[rd] = a ^ b;
							mips_isa_pkg::F_SLT:  ref_regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
							default: ;
						endcase
					end
					mips_isa_pkg::OP_ADDIU: ref_regs[rt] = a + simm;
					mips_isa_pkg::OP_ANDI:  ref_regs[rt] = a & zimm;
					mips_isa_pkg::OP_ORI:   ref_regs[rt] = a | zimm;
					mips_isa_pkg::OP_LUI:   ref_regs[rt] = {w[15:0], 16'd0};
					mips_isa_pkg::OP_LW:    ref_regs[rt] = ref_mem[addr[len_dmem_addr+1:2]];
					mips_isa_pkg::OP_SW: begin
						ref_mem[addr[len_dmem_addr+1:2]] = b;
						mem_touched[addr[len_dmem_addr+1:2]] = 1'b1;
					end
					// offset counts words from pc+4
					mips_isa_pkg::OP_BEQ: if (a == b) next_pc = next_pc + {simm[29:0], 2'b00};
					mips_isa_pkg::OP_BNE: if (a != b) next_pc = next_pc + {simm[29:0], 2'b00};
					mips_isa_pkg::OP_J:    next_pc = {next_pc[31:28], w[25:0], 2'b00};
					mips_isa_pkg::OP_HALT: done = 1'b1;
					default: ;
				endcase
				// r0 is hardwired
				ref_regs[0] = '0;
				pc = next_pc;
				steps++;
			end
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// drive and compare
	//////////////////////////////////////////////////////////////////////
	task automatic check_value(input string label, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %s: expected %08h, actual %08h", label, expected, actual);
		end
	endtask

	// pipeline stays frozen after reset until the program is in
	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b1;
		debug_flag <= 1'b1;
		wea_ram_inst <= 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic load_program();
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			in_addr_mem_inst <= len_addr'(i);
			in_ins_to_mem <= prog[i];
			wea_ram_inst <= 1'b1;
		end
		@(posedge clk);
		wea_ram_inst <= 1'b0;
		debug_flag <= 1'b0;
	endtask

	// debug reads are combinational, sampled half a cycle later
	task automatic compare_state();
		for (int r = 0; r < 32; r++) begin
			@(posedge clk);
			debug_reg_addr <= 5'(r);
			@(negedge clk);
			check_value($sformatf("debug_reg_data[r%0d]", r), ref_regs[r], debug_reg_data);
		end
		for (int i = 0; i < 2**len_dmem_addr; i++) begin
			if (mem_touched[i]) begin
				@(posedge clk);
				debug_mem_addr <= len_dmem_addr'(i);
				@(negedge clk);
				check_value($sformatf("debug_mem_data[%0d]", i), ref_mem[i], debug_mem_data);
			end
		end
	endtask

	task automatic run_test(input string name, input bit hold_check);
		int          errors_before;
		int          checks_before;
		logic [31:0] pc_at_halt;
		errors_before = errors;
		checks_before = checks;
		tests++;
		apply_reset();
		load_program();
		run_isa();
		do
			@(negedge clk);
		while (halt_flag !== 1'b1);
		if (hold_check) begin
			pc_at_halt = out_pc;
			repeat (20) begin
				@(negedge clk);
				check_value("out_pc", pc_at_halt, out_pc);
				check_value("halt_flag", 32'd1, {31'd0, halt_flag});
			end
		end
		compare_state();
		$display("test %0d %s: %0d checks, %0d errors", tests, name,
			checks - checks_before, errors - errors_before);
	endtask

	//////////////////////////////////////////////////////////////////////
	// programs
	//////////////////////////////////////////////////////////////////////
	task automatic alu_program();
		logic [31:0] imm;
		prog.delete();
		imm = lcg_next();
		load_const(1, lcg_next());
		load_const(2, lcg_next());
		emit(rtype_word(mips_isa_pkg::F_ADDU, 1, 2, 3));
		emit(rtype_word(mips_isa_pkg::F_SUBU, 1, 2, 4));
		emit(rtype_word(mips_isa_pkg::F_AND, 1, 2, 5));
		emit(rtype_word(mips_isa_pkg::F_OR, 1, 2, 6));
		emit(rtype_word(mips_isa_pkg::F_XOR, 1, 2, 7));
		// both orders so one slt gives 1
		emit(rtype_word(mips_isa_pkg::F_SLT, 1, 2, 8));
		emit(rtype_word(mips_isa_pkg::F_SLT, 2, 1, 9));
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 1, 10, int'(imm[15:0])));
		emit(itype_word(mips_isa_pkg::OP_ANDI, 2, 11, int'(imm[15:0])));
		emit(itype_word(mips_isa_pkg::OP_ORI, 1, 12, int'(imm[15:0])));
		emit(itype_word(mips_isa_pkg::OP_LUI, 0, 13, int'(imm[31:16])));
		end_program();
	endtask

	task automatic forwarding_program();
		prog.delete();
		load_const(1, lcg_next());
		load_const(2, lcg_next());
		emit(rtype_word(mips_isa_pkg::F_ADDU, 1, 2, 3));
		// r3 at distance 1
		emit(rtype_word(mips_isa_pkg::F_SUBU, 3, 1, 4));
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 0, 20, 1));
		// r4 at distance 2, r3 at 3
		emit(rtype_word(mips_isa_pkg::F_XOR, 4, 3, 5));
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 0, 21, 2));
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 0, 22, 3));
		emit(rtype_word(mips_isa_pkg::F_OR, 5, 4, 6));
		emit(rtype_word(mips_isa_pkg::F_AND, 6, 6, 7));
		emit(rtype_word(mips_isa_pkg::F_SLT, 7, 5, 8));
		// write to r0 never forwards
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 1, 0, 'h55));
		emit(rtype_word(mips_isa_pkg::F_ADDU, 0, 2, 9));
		for (int i = 0; i < 4; i++)
			emit(rtype_word(mips_isa_pkg::F_ADDU, 9 + i, 1, 10 + i));
		end_program();
	endtask

	task automatic memory_program();
		prog.delete();
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 0, 1, 'h40));
		load_const(2, lcg_next());
		load_const(3, lcg_next());
		emit(itype_word(mips_isa_pkg::OP_SW, 1, 2, 0));
		emit(itype_word(mips_isa_pkg::OP_SW, 1, 3, 4));
		emit(itype_word(mips_isa_pkg::OP_LW, 1, 4, 0));
		// load-use on rs
		emit(rtype_word(mips_isa_pkg::F_ADDU, 4, 3, 5));
		emit(itype_word(mips_isa_pkg::OP_LW, 1, 6, 4));
		// loaded value straight into store data
		emit(itype_word(mips_isa_pkg::OP_SW, 1, 6, 8));
		emit(itype_word(mips_isa_pkg::OP_LW, 1, 7, 8));
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 7, 8, 1));
		emit(itype_word(mips_isa_pkg::OP_SW, 1, 5, -4));
		emit(itype_word(mips_isa_pkg::OP_LW, 1, 9, -4));
		// load-use on rt
		emit(rtype_word(mips_isa_pkg::F_SUBU, 2, 9, 10));
		end_program();
	endtask

	// word indices in the trailing comments
	task automatic branch_program();
		prog.delete();
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 0, 1, 5));
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 0, 2, 5));
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 0, 3, 6));
		emit(itype_word(mips_isa_pkg::OP_BEQ, 1, 2, 2));         // 3, taken to 6
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 0, 10, 'h11));   // 4
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 0, 11, 'h12));   // 5
		emit(itype_word(mips_isa_pkg::OP_BNE, 1, 3, 1));         // 6, taken to 8
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 0, 12, 'h13));   // 7
		emit(itype_word(mips_isa_pkg::OP_BEQ, 1, 3, 1));         // 8, falls through
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 0, 13, 'h14));   // 9
		emit(itype_word(mips_isa_pkg::OP_BNE, 1, 2, 1));         // 10, falls through
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 0, 14, 'h15));   // 11
		emit(jump_word(14));                                     // 12
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 0, 15, 'h16));   // 13
		emit(rtype_word(mips_isa_pkg::F_ADDU, 13, 14, 16));      // 14
		// backward loop until r4 reaches r3
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 4, 4, 1));       // 15
		emit(itype_word(mips_isa_pkg::OP_BNE, 4, 3, -2));        // 16
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 0, 5, 'h77));    // 17
		end_program();
	endtask

	task automatic halt_program();
		prog.delete();
		load_const(1, lcg_next());
		emit(itype_word(mips_isa_pkg::OP_ADDIU, 1, 2, 3));
		end_program();
	endtask

	initial begin
		rst = 1'b1;
		debug_flag = 1'b1;
		in_addr_mem_inst = '0;
		in_ins_to_mem = '0;
		wea_ram_inst = 1'b0;
		debug_reg_addr = '0;
		debug_mem_addr = '0;
		alu_program();
		run_test("alu", 1'b0);
		forwarding_program();
		run_test("forwarding", 1'b0);
		memory_program();
		run_test("load/store", 1'b0);
		branch_program();
		run_test("control flow", 1'b0);
		halt_program();
		run_test("halt", 1'b1);
		// sticky flag only clears on reset
		apply_reset();
		@(negedge clk);
		check_value("halt_flag", 32'd0, {31'd0, halt_flag});
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* mips.f */
src/mips_isa_pkg.sv
src/mips_ctrl_pkg.sv
src/pipe_regs_if.sv
src/stage_if.sv
src/stage_id.sv
src/stage_ex.sv
src/stage_mem.sv
src/top_mips.sv
verif/tb_top_mips.sv

/* run_sim.sh */
#!/bin/sh
# build and run the top_mips testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/10ps -f mips.f --top-module tb_top_mips \
	-o sim_top_mips
out=$(./obj_dir/sim_top_mips)
echo "$out"
if echo "$out" | grep -qF -- '*** PASSED ***'; then
	exit 0
fi
exit 1
